/* Bender.yml */
package:
  name: frv_masked

sources:
  - frv_masked_pkg.sv
  - frv_alu_if.sv
  - frv_masked_wr.sv
  - frv_masked_alu.sv
  - frv_masked_rd.sv
  - frv_masked_top.sv
  - target: simulation
    files:
      - tb_frv_masked_top.sv

/* frv_alu_if.sv */
/*
 * Request and response bundle between the write side,
 * the masked ALU and the read side
 */
`timescale 1ns/1ps
`default_nettype none

interface frv_alu_if
    import frv_masked_pkg::*;
();

    // Request held stable until valid and ready meet
    logic    valid;
    logic    ready;                                // High only while ALU idle
    alu_op_e op;
    word_t   rs1_s0;
    word_t   rs1_s1;
    word_t   rs2_s0;
    word_t   rs2_s1;

    // Response as a one-cycle pulse without back-pressure
    logic    rsp_valid;
    word_t   rd_s0;
    word_t   rd_s1;
    logic    err;                                  // Op outside the enum

    modport req (output valid, op, rs1_s0, rs1_s1, rs2_s0, rs2_s1, input ready);
    modport alu (input valid, op, rs1_s0, rs1_s1, rs2_s0, rs2_s1,
                 output ready, rsp_valid, rd_s0, rd_s1, err);
    modport rsp (input rsp_valid, rd_s0, rd_s1, err);

endinterface

`default_nettype wire

/* frv_masked_alu.sv */
/*
 * Masked ALU with an internal LFSR for fresh masks
 * Linear ops finish in one cycle, AND and OR in two
 */
`timescale 1ns/1ps
`default_nettype none

module frv_masked_alu
    import frv_masked_pkg::*;
(
    input  wire    g_clk,
    input  wire    rst,
    frv_alu_if.alu alu
);

    alu_state_e state;
    word_t      lfsr;
    word_t      r;                                 // Fresh random word
    logic       accept;
    logic       is_or;
    logic       is_and_path;                       // AND or OR
    word_t      a0;
    word_t      a1;
    word_t      b0;
    word_t      b1;
    word_t      q_a0b0;                            // Stage 1 products
    word_t      q_a0b1;
    word_t      q_a1b0;
    word_t      q_a1b1;
    logic       inv_q;                             // Invert share 0 for OR
    word_t      unm_s0;
    word_t      unm_s1;
    word_t      res_s0;
    word_t      res_s1;
    logic       res_err;

    assign r             = lfsr;
    assign accept        = alu.valid & alu.ready;
    assign alu.ready     = state == IDLE;
    assign alu.rsp_valid = state == DONE;

    // --------------------
    // Galois LFSR stepping every cycle
    always_ff @(posedge g_clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[XLEN-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
        end
    end

    // --------------------
    // Single-cycle ops
    assign unm_s0 = alu.rs1_s0 & {XLEN{alu.op == OP_B_UNMASK}}; // Gate so rs1 is not
    assign unm_s1 = alu.rs1_s1 & {XLEN{alu.op == OP_B_UNMASK}}; // recombined every op

    always_comb begin
        res_s0  = '0;
        res_s1  = '0;
        res_err = 1'b0;
        case (alu.op)
            OP_B_MASK:   begin
                res_s0 = alu.rs1_s0 ^ r;
                res_s1 = r;
            end
            OP_B_UNMASK: res_s0 = unm_s0 ^ unm_s1;
            OP_B_REMASK: begin
                res_s0 = alu.rs1_s0 ^ r;           // Value unchanged
                res_s1 = alu.rs1_s1 ^ r;
            end
            OP_A_MASK:   begin
                res_s0 = alu.rs1_s0 + r;           // Mod 2^32
                res_s1 = r;
            end
            OP_A_UNMASK: res_s0 = alu.rs1_s0 - alu.rs1_s1;
            OP_B_NOT:    begin
                res_s0 = ~alu.rs1_s0;              // One share inverted
                res_s1 = alu.rs1_s1;
            end
            OP_B_XOR:    begin
                res_s0 = alu.rs1_s0 ^ alu.rs2_s0;
                res_s1 = alu.rs1_s1 ^ alu.rs2_s1;
            end
            OP_B_AND,
            OP_B_IOR:    ;                         // Two-stage path below
            default:     res_err = 1'b1;
        endcase
    end

    // --------------------
    // Masked AND and OR as NOT(AND(NOT a, NOT b))
    assign is_or       = alu.op == OP_B_IOR;
    assign is_and_path = is_or | (alu.op == OP_B_AND);
    assign a0          = is_or ? ~alu.rs1_s0 : alu.rs1_s0;
    assign a1          = alu.rs1_s1;
    assign b0          = is_or ? ~alu.rs2_s0 : alu.rs2_s0;
    assign b1          = alu.rs2_s1;

    always_ff @(posedge g_clk) begin
        if (accept && is_and_path) begin
            q_a0b0 <= (a0 & b0) ^ r;               // Same r refreshes both
            q_a0b1 <= (a0 & b1) ^ r;
            q_a1b0 <= a1 & b0;
            q_a1b1 <= a1 & b1;
            inv_q  <= is_or;
        end
    end

    // Result registers
    always_ff @(posedge g_clk) begin
        if (accept && !is_and_path) begin
            alu.rd_s0 <= res_s0;
            alu.rd_s1 <= res_s1;
            alu.err   <= res_err;
        end else if (state == AND_STAGE) begin
            alu.rd_s0 <= inv_q ? ~q_a0b0 : q_a0b0;
            alu.rd_s1 <= q_a1b1 ^ q_a0b1 ^ q_a1b0; // Combined one cycle late
            alu.err   <= 1'b0;
        end
    end

    // --------------------
    // FSM
    always_ff @(posedge g_clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (accept) state <= is_and_path ? AND_STAGE : DONE;
                AND_STAGE: state <= DONE;
                DONE:      state <= IDLE;          // rsp_valid for one cycle
                default:   state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* frv_masked_pkg.sv */
/*
 * Shared definitions for the masked ALU coprocessor
 * Data and offset types, AXI response codes, opcodes,
 * register map, LFSR constants and the ALU FSM states
 */
`default_nettype none

package frv_masked_pkg;

    // --------------------
    // Widths and types
    localparam int XLEN = 32;                      // Data width

    typedef logic [XLEN-1:0] word_t;               // One share or data word
    typedef logic [7:0]      addr_t;               // Register byte offset
    typedef logic [1:0]      resp_t;               // AXI response code

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // --------------------
    // Opcodes with codes 9..15 illegal
    typedef enum logic [3:0] {
        OP_B_MASK   = 4'd0,                        // Boolean mask
        OP_B_UNMASK = 4'd1,                        // Boolean unmask
        OP_B_REMASK = 4'd2,                        // Boolean remask
        OP_A_MASK   = 4'd3,                        // Arithmetic mask
        OP_A_UNMASK = 4'd4,                        // Arithmetic unmask
        OP_B_NOT    = 4'd5,                        // Masked NOT
        OP_B_XOR    = 4'd6,                        // Masked XOR
        OP_B_AND    = 4'd7,                        // Masked AND, two stages
        OP_B_IOR    = 4'd8                         // Masked OR via AND
    } alu_op_e;

    // --------------------
    // Register map
    localparam addr_t REG_RS1_S0 = 8'h00;          // Write only
    localparam addr_t REG_RS1_S1 = 8'h04;
    localparam addr_t REG_RS2_S0 = 8'h08;
    localparam addr_t REG_RS2_S1 = 8'h0C;
    localparam addr_t REG_OP     = 8'h10;          // Write starts the op
    localparam addr_t REG_STATUS = 8'h14;          // Read only
    localparam addr_t REG_RD_S0  = 8'h18;
    localparam addr_t REG_RD_S1  = 8'h1C;

    // Randomness source
    localparam word_t LFSR_SEED = 32'h5A17_C3E9;   // Any nonzero value
    localparam word_t LFSR_TAPS = 32'h8020_0003;   // x^32+x^22+x^2+x+1

    typedef enum logic [1:0] {
        IDLE,                                      // Ready for a request
        AND_STAGE,                                 // Cross products held
        DONE                                       // Response on the bus
    } alu_state_e;

endpackage

`default_nettype wire

/* frv_masked_rd.sv */
/*
 * AXI4-Lite read path of the masked ALU coprocessor
 * Captures ALU results, keeps busy and done flags,
 * serves the status word and the result shares
 */
`timescale 1ns/1ps
`default_nettype none

module frv_masked_rd
    import frv_masked_pkg::*;
(
    input  wire        g_clk,
    input  wire        rst,
    input  wire        arvalid,
    output logic       arready,
    input  wire addr_t araddr,
    output logic       rvalid,
    input  wire        rready,
    output word_t      rdata,
    output resp_t      rresp,
    input  wire        launch,                     // Op started on write side
    frv_alu_if.rsp     alu
);

    word_t res_s0;                                 // Captured result shares
    word_t res_s1;
    logic  res_err;
    logic  busy;
    logic  done;
    logic  rd_fire;
    word_t status;

    assign rd_fire = arready & arvalid;
    assign status  = {{(XLEN-3){1'b0}}, res_err, done, busy};

    // --------------------
    // Result capture and flags
    always_ff @(posedge g_clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            res_err <= 1'b0;
        end else if (launch) begin
            busy <= 1'b1;
            done <= 1'b0;                          // Cleared by next op
        end else if (alu.rsp_valid) begin
            busy    <= 1'b0;
            done    <= 1'b1;
            res_err <= alu.err;
        end
    end

    always_ff @(posedge g_clk) begin
        if (alu.rsp_valid) begin
            res_s0 <= alu.rd_s0;
            res_s1 <= alu.rd_s1;
        end
    end

    // --------------------
    // Read channel
    always_ff @(posedge g_clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ~arready & ~rvalid & arvalid; // One-cycle accept
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Address decode
    always_ff @(posedge g_clk) begin
        if (rd_fire) begin
            rresp <= RESP_OKAY;
            case (araddr)
                REG_STATUS: rdata <= status;
                REG_RD_S0:  rdata <= res_s0;
                REG_RD_S1:  rdata <= res_s1;
                default: begin
                    rdata <= '0;                   // Write-only or unmapped
                    rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* frv_masked_top.sv */
/*
 * Top level of the masked ALU coprocessor
 * Plain AXI4-Lite slave ports, write path, ALU and read path
 */
`timescale 1ns/1ps
`default_nettype none

module frv_masked_top
    import frv_masked_pkg::*;
(
    input  wire        g_clk,                      // Global clock
    input  wire        rst,                        // Synchronous, active high
    // Write address and data
    input  wire        awvalid,
    output wire        awready,
    input  wire addr_t awaddr,
    input  wire        wvalid,
    output wire        wready,
    input  wire word_t wdata,
    input  wire [3:0]  wstrb,
    // Write response
    output wire        bvalid,
    input  wire        bready,
    output wire resp_t bresp,
    // Read address and data
    input  wire        arvalid,
    output wire        arready,
    input  wire addr_t araddr,
    output wire        rvalid,
    input  wire        rready,
    output wire word_t rdata,
    output wire resp_t rresp
);

    wire launch;                                   // Write side to read side

    frv_alu_if alu_bus ();

    frv_masked_wr u_wr (
        .g_clk   (g_clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .launch  (launch),
        .alu     (alu_bus.req)
    );

    frv_masked_alu u_alu (
        .g_clk (g_clk),
        .rst   (rst),
        .alu   (alu_bus.alu)
    );

    frv_masked_rd u_rd (
        .g_clk   (g_clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .launch  (launch),
        .alu     (alu_bus.rsp)
    );

endmodule

`default_nettype wire

/* frv_masked_wr.sv */
/*
 * AXI4-Lite write path of the masked ALU coprocessor
 * Holds the operand share registers and the op register,
 * raises the ALU request and pulses launch
 */
`timescale 1ns/1ps
`default_nettype none

module frv_masked_wr
    import frv_masked_pkg::*;
(
    input  wire        g_clk,
    input  wire        rst,
    input  wire        awvalid,
    output logic       awready,
    input  wire addr_t awaddr,
    input  wire        wvalid,
    output logic       wready,
    input  wire word_t wdata,
    input  wire [3:0]  wstrb,
    output logic       bvalid,
    input  wire        bready,
    output resp_t      bresp,
    output logic       launch,                     // One cycle per started op
    frv_alu_if.req     alu
);

    logic aw_ready_q;                              // Shared AW and W ready
    logic wr_fire;                                 // Address and data taken
    logic strb_ok;
    logic op_legal;
    logic op_pending;
    logic is_operand;
    logic wr_ok;
    logic op_start;

    assign awready = aw_ready_q;
    assign wready  = aw_ready_q;

    // --------------------
    // Decode
    assign wr_fire    = aw_ready_q & awvalid & wvalid;
    assign strb_ok    = &wstrb;                    // Full words only
    assign op_legal   = wdata <= word_t'(OP_B_IOR); // Upper bits must be zero
    assign op_pending = alu.valid | ~alu.ready;    // Queued or ALU working
    assign is_operand = (awaddr == REG_RS1_S0) | (awaddr == REG_RS1_S1) |
                        (awaddr == REG_RS2_S0) | (awaddr == REG_RS2_S1);
    assign wr_ok      = strb_ok & (is_operand |
                        ((awaddr == REG_OP) & op_legal & ~op_pending));
    assign op_start   = wr_fire & wr_ok & (awaddr == REG_OP);

    // --------------------
    // Channel handshake
    always_ff @(posedge g_clk) begin
        if (rst) begin
            aw_ready_q <= 1'b0;
            bvalid     <= 1'b0;
        end else begin
            aw_ready_q <= ~aw_ready_q & ~bvalid & awvalid & wvalid; // Single-cycle pulse
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;                    // Held until master takes it
            end
        end
    end

    // Request valid and launch pulse
    always_ff @(posedge g_clk) begin
        if (rst) begin
            alu.valid <= 1'b0;
            launch    <= 1'b0;
        end else begin
            launch <= op_start;
            if (op_start) begin
                alu.valid <= 1'b1;
            end else if (alu.ready) begin
                alu.valid <= 1'b0;                 // Transfer done
            end
        end
    end

    // Share registers, op and response code
    always_ff @(posedge g_clk) begin
        if (wr_fire) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            if (wr_ok) begin
                case (awaddr)
                    REG_RS1_S0: alu.rs1_s0 <= wdata;
                    REG_RS1_S1: alu.rs1_s1 <= wdata;
                    REG_RS2_S0: alu.rs2_s0 <= wdata;
                    REG_RS2_S1: alu.rs2_s1 <= wdata;
                    REG_OP:     alu.op     <= alu_op_e'(wdata[3:0]);
                    default:    ;                  // Excluded by wr_ok
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* tb_frv_masked_top.sv */
/*
 * Directed testbench for the masked ALU coprocessor
 * AXI4-Lite bus tasks, LFSR operand source, per-behavior tests,
 * error counting and a cycle watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_frv_masked_top
    import frv_masked_pkg::*;
();

    localparam int RUN_CYCLES = 40;                // Worst case for one full run
    localparam int NUM_RUNS   = 130;               // Runs plus extra bus traffic
    localparam int TIMEOUT    = 4 * (RUN_CYCLES * NUM_RUNS + 10);

    logic  g_clk;
    logic  rst;
    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    logic  wvalid;
    logic  wready;
    word_t wdata;
    logic  [3:0] wstrb;
    logic  bvalid;
    logic  bready;
    resp_t bresp;
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    logic  rvalid;
    logic  rready;
    word_t rdata;
    resp_t rresp;

    int    checks = 0;
    int    errors = 0;
    int    cycles = 0;
    word_t lfsr_state = 32'h786cc50f;              // Operand source seed

    frv_masked_top uut (
        .g_clk (g_clk), .rst (rst),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;                 // 4 ns period
    end

    always @(posedge g_clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // Helpers
    function automatic word_t rand_word();
        word_t val;
        logic  fb;
        val = '0;
        for (int i = 0; i < XLEN; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};   // One step per bit
            val        = {val[XLEN-2:0], fb};
        end
        return val;
    endfunction

    task automatic verify(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    // Starts and ends on a falling edge
    task automatic axi_write(input addr_t addr, input word_t data, input logic [3:0] strb,
                             output resp_t resp);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        @(negedge g_clk);
        while (!awready) @(negedge g_clk);         // Ready pulse seen
        verify(wready, "wready did not rise with awready");
        @(negedge g_clk);                          // Taken on the edge before
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid) @(negedge g_clk);
        resp = bresp;
        @(negedge g_clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output word_t data, output resp_t resp);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge g_clk);
        while (!arready) @(negedge g_clk);
        @(negedge g_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge g_clk);
        data = rdata;
        resp = rresp;
        @(negedge g_clk);
        rready = 1'b0;
    endtask

    task automatic write_ok(input addr_t addr, input word_t data);
        resp_t resp;
        axi_write(addr, data, 4'hF, resp);
        verify(resp == RESP_OKAY, $sformatf("write to %h gave resp %b", addr, resp));
    endtask

    task automatic read_ok(input addr_t addr, output word_t data);
        resp_t resp;
        axi_read(addr, data, resp);
        verify(resp == RESP_OKAY, $sformatf("read of %h gave resp %b", addr, resp));
    endtask

    task automatic wait_done(output word_t st);
        st = '0;
        while (!st[1]) read_ok(REG_STATUS, st);    // Poll the done bit
    endtask

    // Full run of shares in, op, poll and shares out
    task automatic run_op(input alu_op_e op, input word_t a0, a1, b0, b1,
                          output word_t rd0, rd1);
        word_t st;
        write_ok(REG_RS1_S0, a0);
        write_ok(REG_RS1_S1, a1);
        write_ok(REG_RS2_S0, b0);
        write_ok(REG_RS2_S1, b1);
        write_ok(REG_OP, word_t'(op));
        wait_done(st);
        verify(st[2:0] == 3'b010, $sformatf("%s status %b", op.name(), st[2:0]));
        read_ok(REG_RD_S0, rd0);
        read_ok(REG_RD_S1, rd1);
    endtask

    task automatic results_unchanged(input word_t e0, e1, input string what);
        word_t d0;
        word_t d1;
        read_ok(REG_RD_S0, d0);
        read_ok(REG_RD_S1, d1);
        verify(d0 == e0 && d1 == e1, $sformatf("results changed after %s", what));
    endtask

    // --------------------
    // Tests
    task automatic reset_state();
        word_t st;
        resp_t resp;
        verify(!bvalid && !rvalid && !awready && !wready && !arready, "channels busy at reset");
        axi_read(REG_STATUS, st, resp);
        verify(resp == RESP_OKAY && st == '0, $sformatf("status after reset %h", st));
        axi_write(REG_RS1_S0, rand_word(), 4'hF, resp);
        verify(resp == RESP_OKAY, "first write after reset not OKAY");
    endtask

    task automatic boolean_masking();
        word_t v;
        word_t s0;
        word_t s1;
        for (int i = 0; i < 8; i++) begin
            v = rand_word();
            run_op(OP_B_MASK, v, rand_word(), '0, '0, s0, s1);
            verify((s0 ^ s1) == v, $sformatf("B mask %h gave %h", v, s0 ^ s1));
            run_op(OP_B_REMASK, s0, s1, '0, '0, s0, s1); // Chained on the masked shares
            verify((s0 ^ s1) == v, $sformatf("B remask %h gave %h", v, s0 ^ s1));
            run_op(OP_B_UNMASK, s0, s1, '0, '0, s0, s1);
            verify(s0 == v && s1 == '0, $sformatf("B unmask %h gave %h %h", v, s0, s1));
        end
    endtask

    task automatic arith_masking();
        word_t v;
        word_t a;
        word_t b;
        word_t s0;
        word_t s1;
        for (int i = 0; i < 8; i++) begin
            v = rand_word();
            run_op(OP_A_MASK, v, rand_word(), '0, '0, s0, s1);
            verify(word_t'(s0 - s1) == v, $sformatf("A mask %h gave %h", v, s0 - s1));
            a = rand_word();
            b = rand_word();
            run_op(OP_A_UNMASK, a, b, '0, '0, s0, s1);
            verify(s0 == word_t'(a - b) && s1 == '0, $sformatf("A unmask gave %h %h", s0, s1));
        end
    endtask

    task automatic logic_ops(input alu_op_e op);
        word_t v;
        word_t w;
        word_t m1;
        word_t m2;
        word_t exp;
        word_t s0;
        word_t s1;
        for (int i = 0; i < 20; i++) begin
            v  = rand_word();
            w  = rand_word();
            m1 = rand_word();                      // Input masks
            m2 = rand_word();
            case (op)
                OP_B_NOT: exp = ~v;
                OP_B_XOR: exp = v ^ w;
                OP_B_AND: exp = v & w;
                default:  exp = v | w;
            endcase
            run_op(op, v ^ m1, m1, w ^ m2, m2, s0, s1);
            verify((s0 ^ s1) == exp,
                   $sformatf("%s %h %h gave %h exp %h", op.name(), v, w, s0 ^ s1, exp));
        end
    endtask

    task automatic status_flags();
        word_t st;
        word_t v;
        word_t w;
        word_t m1;
        word_t m2;
        word_t r0;
        word_t r1;
        v  = rand_word();
        w  = rand_word();
        m1 = rand_word();
        m2 = rand_word();
        write_ok(REG_RS1_S0, v ^ m1);
        write_ok(REG_RS1_S1, m1);
        write_ok(REG_RS2_S0, w ^ m2);
        write_ok(REG_RS2_S1, m2);
        write_ok(REG_OP, word_t'(OP_B_AND));       // Two-stage op keeps busy longest
        read_ok(REG_STATUS, st);
        verify(st[1:0] == 2'b01, $sformatf("status after launch %b", st[1:0]));
        wait_done(st);
        verify(!st[0], "busy still set with done");
        read_ok(REG_RD_S0, r0);
        read_ok(REG_RD_S1, r1);
        verify((r0 ^ r1) == (v & w), $sformatf("AND %h %h gave %h", v, w, r0 ^ r1));
        write_ok(REG_OP, word_t'(OP_B_IOR));       // Also two stages
        read_ok(REG_STATUS, st);
        verify(!st[1], "done not cleared by the next launch");
        wait_done(st);
    endtask

    task automatic error_responses();
        word_t r0;
        word_t r1;
        word_t d;
        resp_t resp;
        run_op(OP_B_XOR, rand_word(), rand_word(), rand_word(), rand_word(), r0, r1);
        axi_write(REG_OP, 32'd9, 4'hF, resp);
        verify(resp == RESP_SLVERR, "illegal opcode accepted");
        read_ok(REG_STATUS, d);
        verify(d[2:0] == 3'b010, $sformatf("illegal opcode left status %b", d[2:0]));
        results_unchanged(r0, r1, "illegal opcode");
        axi_read(REG_OP, d, resp);
        verify(resp == RESP_SLVERR && d == '0, $sformatf("REG_OP read %b %h", resp, d));
        axi_read(REG_RS2_S1, d, resp);
        verify(resp == RESP_SLVERR && d == '0, $sformatf("RS2_S1 read %b %h", resp, d));
        results_unchanged(r0, r1, "write-only read");
        axi_write(REG_OP, word_t'(OP_B_MASK), 4'b0111, resp); // Would launch if taken
        verify(resp == RESP_SLVERR, "partial strobe write accepted");
        axi_write(REG_STATUS, rand_word(), 4'hF, resp);
        verify(resp == RESP_SLVERR, "write to status accepted");
        results_unchanged(r0, r1, "partial strobe write");
    endtask

    // --------------------
    // Main sequence
    initial begin
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (5) @(negedge g_clk);               // Five reset cycles
        rst = 1'b0;
        reset_state();
        boolean_masking();
        arith_masking();
        logic_ops(OP_B_NOT);
        logic_ops(OP_B_XOR);
        logic_ops(OP_B_AND);
        logic_ops(OP_B_IOR);
        status_flags();
        error_responses();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
frv_masked_pkg.sv
frv_alu_if.sv
frv_masked_wr.sv
frv_masked_alu.sv
frv_masked_rd.sv
frv_masked_top.sv
tb_frv_masked_top.sv
